// File: hdl/privPkg.sv
`default_nettype none

package privPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Privilege modes
  ////////////////////////////////////////////////////////////////////////////

  parameter logic [1:0] UMode = 2'b00;  // User
  parameter logic [1:0] SMode = 2'b01;  // Supervisor
  parameter logic [1:0] MMode = 2'b11;  // Machine, 10 is reserved

  ////////////////////////////////////////////////////////////////////////////
  // CSR addresses
  ////////////////////////////////////////////////////////////////////////////

  // Bits 9:8 of each address give the lowest mode allowed to touch it
  parameter logic [11:0] AddrUstatus = 12'h000;
  parameter logic [11:0] AddrSstatus = 12'h100;
  parameter logic [11:0] AddrMstatus = 12'h300;
  parameter logic [11:0] AddrMedeleg = 12'h302;

  ////////////////////////////////////////////////////////////////////////////
  // Status field bit positions
  ////////////////////////////////////////////////////////////////////////////

  parameter int BitUie  = 0;
  parameter int BitSie  = 1;
  parameter int BitMie  = 3;
  parameter int BitUpie = 4;
  parameter int BitSpie = 5;
  parameter int BitMpie = 7;
  parameter int BitSpp  = 8;
  parameter int BitMpp  = 11;  // Low bit of the two bit MPP field
  parameter int BitFs   = 13;  // Low bit of the two bit FS field
  parameter int BitMprv = 17;
  parameter int BitSum  = 18;

  // FS encodings, only dirty is needed by the hardware
  parameter logic [1:0] FsDirty = 2'b11;

endpackage

`default_nettype wire

// File: hdl/csrAccess.sv
`default_nettype none

module csrAccess #(
  parameter int Xlen       = 64,
  parameter bit SSupported = 1'b1,
  parameter bit USupported = 1'b1
) (
  input  logic [1:0]      privilegeMode,
  input  logic            csrWrite,
  input  logic [11:0]     csrAddr,
  input  logic [Xlen-1:0] mstatusVal,
  input  logic [Xlen-1:0] sstatusVal,
  input  logic [Xlen-1:0] ustatusVal,
  input  logic [Xlen-1:0] medelegVal,
  output logic            writeMstatus,
  output logic            writeSstatus,
  output logic            writeUstatus,
  output logic            writeMedeleg,
  output logic            illegalCsr,
  output logic [Xlen-1:0] csrRdata
);

  logic hitM, hitS, hitU, hitDeleg;  // One hot address match
  logic knownAddr;
  logic privTooLow;

  // Views of absent modes do not exist at all
  assign hitM     = (csrAddr == privPkg::AddrMstatus);
  assign hitS     = (csrAddr == privPkg::AddrSstatus) && SSupported;
  assign hitU     = (csrAddr == privPkg::AddrUstatus) && USupported;
  assign hitDeleg = (csrAddr == privPkg::AddrMedeleg);

  assign knownAddr  = hitM | hitS | hitU | hitDeleg;
  assign privTooLow = (privilegeMode < csrAddr[9:8]);  // Encoded min mode
  assign illegalCsr = ~knownAddr | privTooLow;

  // Write strobes only for legal accesses
  assign writeMstatus = csrWrite & hitM & ~illegalCsr;
  assign writeSstatus = csrWrite & hitS & ~illegalCsr;
  assign writeUstatus = csrWrite & hitU & ~illegalCsr;
  assign writeMedeleg = csrWrite & hitDeleg & ~illegalCsr;

  // Read mux, zero on illegal access
  always_comb begin
    csrRdata = '0;
    if (!illegalCsr) begin
      if (hitM)     csrRdata = mstatusVal;
      if (hitS)     csrRdata = sstatusVal;
      if (hitU)     csrRdata = ustatusVal;
      if (hitDeleg) csrRdata = medelegVal;
    end
  end

endmodule

`default_nettype wire

// File: hdl/statusReg.sv
`default_nettype none

module statusReg #(
  parameter int Xlen       = 64,
  parameter bit SSupported = 1'b1,
  parameter bit USupported = 1'b1,
  parameter bit FSupported = 1'b1
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            stall,
  input  logic            writeMstatus,
  input  logic            writeSstatus,
  input  logic            writeUstatus,
  input  logic [Xlen-1:0] csrWdata,
  input  logic            trapTaken,
  input  logic [1:0]      trapTarget,
  input  logic [1:0]      privilegeMode,
  input  logic            mret,
  input  logic            sret,
  input  logic            uret,
  input  logic            floatRegWrite,
  output logic [Xlen-1:0] mstatusVal,
  output logic [Xlen-1:0] sstatusVal,
  output logic [Xlen-1:0] ustatusVal,
  output logic            statusMie,
  output logic [1:0]      statusMpp,
  output logic            statusSpp
);

  // Raw storage, masked on the way out
  logic       mieQ, sieQ, uieQ;
  logic       mpieQ, spieQ, upieQ;
  logic       sppQ, mprvQ, sumQ;
  logic [1:0] mppQ, fsQ;

  // Visible field values
  logic       sie, uie, spie, upie, spp, mprv, sum, sd;
  logic [1:0] fs;
  logic [1:0] mppNext;  // WARL legalized MPP from write data

  ////////////////////////////////////////////////////////////////////////////
  // WARL masking
  ////////////////////////////////////////////////////////////////////////////

  assign sie  = SSupported & sieQ;
  assign spie = SSupported & spieQ;
  assign spp  = SSupported & sppQ;
  assign sum  = SSupported & sumQ;
  assign uie  = USupported & uieQ;
  assign upie = USupported & upieQ;
  assign mprv = USupported & mprvQ;   // No lower mode, nothing to modify
  assign fs   = (FSupported && SSupported) ? fsQ : 2'b00;
  assign sd   = (fs == privPkg::FsDirty);  // XS is always zero

  // Unsupported or reserved MPP values fall back to M
  always_comb begin
    if (csrWdata[privPkg::BitMpp+1:privPkg::BitMpp] == privPkg::UMode && USupported)
      mppNext = privPkg::UMode;
    else if (csrWdata[privPkg::BitMpp+1:privPkg::BitMpp] == privPkg::SMode && SSupported)
      mppNext = privPkg::SMode;
    else
      mppNext = privPkg::MMode;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Register views
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    mstatusVal = '0;
    mstatusVal[privPkg::BitUie]  = uie;
    mstatusVal[privPkg::BitSie]  = sie;
    mstatusVal[privPkg::BitMie]  = mieQ;
    mstatusVal[privPkg::BitUpie] = upie;
    mstatusVal[privPkg::BitSpie] = spie;
    mstatusVal[privPkg::BitMpie] = mpieQ;
    mstatusVal[privPkg::BitSpp]  = spp;
    mstatusVal[privPkg::BitMpp+1:privPkg::BitMpp] = mppQ;
    mstatusVal[privPkg::BitFs+1:privPkg::BitFs]   = fs;
    mstatusVal[privPkg::BitMprv] = mprv;
    mstatusVal[privPkg::BitSum]  = sum;
    mstatusVal[Xlen-1]           = sd;     // SD sits in the top bit for both widths
  end

  // Supervisor subset hides all M fields
  always_comb begin
    sstatusVal = '0;
    sstatusVal[privPkg::BitUie]  = uie;
    sstatusVal[privPkg::BitSie]  = sie;
    sstatusVal[privPkg::BitUpie] = upie;
    sstatusVal[privPkg::BitSpie] = spie;
    sstatusVal[privPkg::BitSpp]  = spp;
    sstatusVal[privPkg::BitFs+1:privPkg::BitFs] = fs;
    sstatusVal[privPkg::BitSum]  = sum;
    sstatusVal[Xlen-1]           = sd;
  end

  always_comb begin
    ustatusVal = '0;
    ustatusVal[privPkg::BitUie]  = uie;
    ustatusVal[privPkg::BitUpie] = upie;
  end

  assign statusMie = mieQ;
  assign statusMpp = mppQ;
  assign statusSpp = spp;

  ////////////////////////////////////////////////////////////////////////////
  // Field updates, CSR write beats trap, trap beats xRET
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mieQ  <= 1'b0;
      sieQ  <= 1'b0;
      uieQ  <= 1'b0;
      mpieQ <= 1'b0;
      spieQ <= 1'b0;
      upieQ <= 1'b0;
      sppQ  <= 1'b0;
      mppQ  <= 2'b00;
      mprvQ <= 1'b0;
      sumQ  <= 1'b0;
    end else if (!stall) begin
      if (writeMstatus) begin
        mieQ  <= csrWdata[privPkg::BitMie];
        sieQ  <= csrWdata[privPkg::BitSie];
        uieQ  <= csrWdata[privPkg::BitUie];
        mpieQ <= csrWdata[privPkg::BitMpie];
        spieQ <= csrWdata[privPkg::BitSpie];
        upieQ <= csrWdata[privPkg::BitUpie];
        sppQ  <= csrWdata[privPkg::BitSpp];
        mppQ  <= mppNext;
        mprvQ <= csrWdata[privPkg::BitMprv];
        sumQ  <= csrWdata[privPkg::BitSum];
      end else if (writeSstatus) begin        // Only the S visible subset
        sieQ  <= csrWdata[privPkg::BitSie];
        uieQ  <= csrWdata[privPkg::BitUie];
        spieQ <= csrWdata[privPkg::BitSpie];
        upieQ <= csrWdata[privPkg::BitUpie];
        sppQ  <= csrWdata[privPkg::BitSpp];
        sumQ  <= csrWdata[privPkg::BitSum];
      end else if (writeUstatus) begin
        uieQ  <= csrWdata[privPkg::BitUie];
        upieQ <= csrWdata[privPkg::BitUpie];
      end else if (trapTaken) begin
        // Stack the enable of the target mode and record where we came from
        if (trapTarget == privPkg::MMode) begin
          mpieQ <= mieQ;
          mieQ  <= 1'b0;
          mppQ  <= privilegeMode;
        end else if (trapTarget == privPkg::SMode) begin
          spieQ <= sie;
          sieQ  <= 1'b0;
          sppQ  <= privilegeMode[0];           // U is 0, S is 1
        end else begin
          upieQ <= uie;
          uieQ  <= 1'b0;
        end
      end else if (mret) begin
        mieQ  <= mpieQ;
        mpieQ <= 1'b1;
        mppQ  <= USupported ? privPkg::UMode : privPkg::MMode;  // Least mode
        mprvQ <= 1'b0;
      end else if (sret) begin
        sieQ  <= spieQ;
        spieQ <= 1'b1;
        sppQ  <= 1'b0;
        mprvQ <= 1'b0;                         // Leaving M territory
      end else if (uret) begin
        uieQ  <= upieQ;
        upieQ <= 1'b1;
      end
    end
  end

  // FS has its own source in float register writes
  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      fsQ <= 2'b00;
    else if (!stall) begin
      if (writeMstatus || writeSstatus)
        fsQ <= csrWdata[privPkg::BitFs+1:privPkg::BitFs];
      else if (floatRegWrite)
        fsQ <= privPkg::FsDirty;               // Mark float state dirty
    end
  end

  // Legalization holds across writes, traps and returns alike
  assert property (@(posedge clk) disable iff (reset) mppQ != 2'b10)
    else $error("statusReg: MPP holds reserved value 10");

endmodule

`default_nettype wire

// File: hdl/privModeReg.sv
`default_nettype none

module privModeReg (
  input  logic       clk,
  input  logic       reset,
  input  logic       stall,
  input  logic       trapTaken,
  input  logic [1:0] trapTarget,
  input  logic       mret,
  input  logic       sret,
  input  logic       uret,
  input  logic [1:0] statusMpp,
  input  logic       statusSpp,
  output logic [1:0] privilegeMode
);

  logic [1:0] modeNext;

  // Trap has priority over any xRET
  always_comb begin
    modeNext = privilegeMode;                  // Hold by default
    if (trapTaken)
      modeNext = trapTarget;
    else if (mret)
      modeNext = statusMpp;                    // Back to stacked mode
    else if (sret)
      modeNext = statusSpp ? privPkg::SMode : privPkg::UMode;
    else if (uret)
      modeNext = privPkg::UMode;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      privilegeMode <= privPkg::MMode;         // Hart boots in M
    else if (!stall)
      privilegeMode <= modeNext;
  end

  // Needs legal MPP from statusReg and legal targets from trapCtrl
  assert property (@(posedge clk) disable iff (reset) privilegeMode != 2'b10)
    else $error("privModeReg: reserved privilege mode 10");

endmodule

`default_nettype wire

// File: hdl/trapCtrl.sv
`default_nettype none

module trapCtrl #(
  parameter int Xlen       = 64,
  parameter bit SSupported = 1'b1
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            stall,
  input  logic            writeMedeleg,
  input  logic [Xlen-1:0] csrWdata,
  input  logic            exceptionReq,
  input  logic [3:0]      cause,
  input  logic            machineIrq,
  input  logic [1:0]      privilegeMode,
  input  logic            statusMie,
  output logic [Xlen-1:0] medelegVal,
  output logic            trapTaken,
  output logic [1:0]      trapTarget
);

  logic [15:0] medelegQ;       // One bit per 4 bit cause
  logic        irqTaken;
  logic        delegToS;

  ////////////////////////////////////////////////////////////////////////////
  // medeleg storage
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      medelegQ <= '0;
    else if (!stall && writeMedeleg)
      medelegQ <= csrWdata[15:0];
  end

  // Upper bits hardwired, whole register zero with no S mode
  assign medelegVal = SSupported ? {{(Xlen-16){1'b0}}, medelegQ} : '0;

  ////////////////////////////////////////////////////////////////////////////
  // Take and target decision
  ////////////////////////////////////////////////////////////////////////////

  // Lower modes always see M interrupts, M itself only with MIE
  assign irqTaken = machineIrq && ((privilegeMode != privPkg::MMode) || statusMie);

  // Traps from M never go down to S
  assign delegToS = SSupported && (privilegeMode != privPkg::MMode) && medelegQ[cause];

  assign trapTaken = exceptionReq | irqTaken;

  always_comb begin
    trapTarget = privPkg::MMode;               // Interrupts stay in M
    if (exceptionReq && delegToS)              // Exception wins over interrupt
      trapTarget = privPkg::SMode;
  end

endmodule

`default_nettype wire

// File: hdl/privCsrTop.sv
`default_nettype none

module privCsrTop #(
  parameter int Xlen       = 64,
  parameter bit SSupported = 1'b1,
  parameter bit USupported = 1'b1,
  parameter bit FSupported = 1'b1
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            stall,
  input  logic            csrWrite,     // CSR port
  input  logic [11:0]     csrAddr,
  input  logic [Xlen-1:0] csrWdata,
  output logic [Xlen-1:0] csrRdata,
  output logic            illegalCsr,
  input  logic            exceptionReq, // Trap sources
  input  logic [3:0]      cause,
  input  logic            machineIrq,
  input  logic            mret,
  input  logic            sret,
  input  logic            uret,
  input  logic            floatRegWrite,
  output logic            trapTaken,
  output logic [1:0]      privilegeMode
);

  logic            writeMstatus, writeSstatus, writeUstatus, writeMedeleg;
  logic [Xlen-1:0] mstatusVal, sstatusVal, ustatusVal, medelegVal;
  logic            statusMie, statusSpp;
  logic [1:0]      statusMpp;
  logic [1:0]      trapTarget;

  ////////////////////////////////////////////////////////////////////////////
  // Block instances
  ////////////////////////////////////////////////////////////////////////////

  csrAccess #(.Xlen(Xlen), .SSupported(SSupported), .USupported(USupported)) u_access (
    .privilegeMode, .csrWrite, .csrAddr,
    .mstatusVal, .sstatusVal, .ustatusVal, .medelegVal,
    .writeMstatus, .writeSstatus, .writeUstatus, .writeMedeleg,
    .illegalCsr, .csrRdata
  );

  statusReg #(
    .Xlen(Xlen), .SSupported(SSupported), .USupported(USupported), .FSupported(FSupported)
  ) u_status (
    .clk, .reset, .stall,
    .writeMstatus, .writeSstatus, .writeUstatus, .csrWdata,
    .trapTaken, .trapTarget, .privilegeMode,
    .mret, .sret, .uret, .floatRegWrite,
    .mstatusVal, .sstatusVal, .ustatusVal,
    .statusMie, .statusMpp, .statusSpp
  );

  privModeReg u_mode (
    .clk, .reset, .stall,
    .trapTaken, .trapTarget,
    .mret, .sret, .uret,
    .statusMpp, .statusSpp,
    .privilegeMode
  );

  trapCtrl #(.Xlen(Xlen), .SSupported(SSupported)) u_trap (
    .clk, .reset, .stall,
    .writeMedeleg, .csrWdata,
    .exceptionReq, .cause, .machineIrq,
    .privilegeMode, .statusMie,
    .medelegVal, .trapTaken, .trapTarget
  );

endmodule

`default_nettype wire

// File: dv/privCsrTb.sv
`default_nettype none

module privCsrTb;

  localparam int Xlen = 64;
  localparam int CycleLimit = 400;  // Sequence runs ~100 cycles, four times that as margin

  // Writable field masks per view
  localparam logic [63:0] MMask = 64'h679BB;
  localparam logic [63:0] SMask = 64'h46133;
  localparam logic [63:0] UMask = 64'h11;

  logic            clk, reset, stall;
  logic            csrWrite;
  logic [11:0]     csrAddr;
  logic [Xlen-1:0] csrWdata, csrRdata;
  logic            illegalCsr;
  logic            exceptionReq, machineIrq;
  logic [3:0]      cause;
  logic            mret, sret, uret, floatRegWrite;
  logic            trapTaken;
  logic [1:0]      privilegeMode;

  logic [15:0]     lfsr = 16'd54791;
  int              cycleCount = 0;

  // Reference model state
  logic [63:0] mstModel;  // Stored fields only, SD is derived
  logic [63:0] mstNext;
  logic [15:0] delegModel;
  logic [1:0]  modeModel;
  logic [63:0] sdBit, expRdata;
  logic        knownAddr, expIllegal, legalWr, expTrap;
  logic [1:0]  expTarget;

  privCsrTop #(
    .Xlen(Xlen), .SSupported(1'b1), .USupported(1'b1), .FSupported(1'b1)
  ) u_dut (
    .clk, .reset, .stall, .csrWrite, .csrAddr, .csrWdata, .csrRdata, .illegalCsr,
    .exceptionReq, .cause, .machineIrq, .mret, .sret, .uret, .floatRegWrite,
    .trapTaken, .privilegeMode
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  assign sdBit     = {mstModel[14:13] == 2'b11, 63'b0};  // Dirty FS shows in SD
  assign knownAddr = (csrAddr == privPkg::AddrMstatus) || (csrAddr == privPkg::AddrSstatus) ||
                     (csrAddr == privPkg::AddrUstatus) || (csrAddr == privPkg::AddrMedeleg);
  assign expIllegal = !knownAddr || (modeModel < csrAddr[9:8]);
  assign legalWr    = csrWrite && !expIllegal;
  assign expTrap    = exceptionReq || (machineIrq && (modeModel != privPkg::MMode || mstModel[3]));
  assign expTarget  = (exceptionReq && modeModel != privPkg::MMode && delegModel[cause]) ?
                      privPkg::SMode : privPkg::MMode;

  always_comb begin
    expRdata = '0;
    if (!expIllegal) begin
      case (csrAddr)
        privPkg::AddrMstatus: expRdata = mstModel | sdBit;
        privPkg::AddrSstatus: expRdata = (mstModel & SMask) | sdBit;
        privPkg::AddrUstatus: expRdata = mstModel & UMask;
        privPkg::AddrMedeleg: expRdata = {48'b0, delegModel};
        default:              expRdata = '0;
      endcase
    end
  end

  // Write beats trap, trap beats xRET
  always_comb begin
    mstNext = mstModel;
    if (legalWr && csrAddr == privPkg::AddrMstatus) begin
      mstNext = csrWdata & MMask;
      if (mstNext[12:11] == 2'b10)
        mstNext[12:11] = privPkg::MMode;       // Reserved MPP
    end else if (legalWr && csrAddr == privPkg::AddrSstatus) begin
      mstNext = (mstModel & ~SMask) | (csrWdata & SMask);
    end else if (legalWr && csrAddr == privPkg::AddrUstatus) begin
      mstNext = (mstModel & ~UMask) | (csrWdata & UMask);
    end else if (expTrap && expTarget == privPkg::MMode) begin
      mstNext[7]     = mstModel[3];            // MPIE gets MIE
      mstNext[3]     = 1'b0;
      mstNext[12:11] = modeModel;
    end else if (expTrap) begin
      mstNext[5] = mstModel[1];                // SPIE gets SIE
      mstNext[1] = 1'b0;
      mstNext[8] = modeModel[0];
    end else if (mret) begin
      mstNext[3]     = mstModel[7];
      mstNext[7]     = 1'b1;
      mstNext[12:11] = privPkg::UMode;
      mstNext[17]    = 1'b0;
    end else if (sret) begin
      mstNext[1]  = mstModel[5];
      mstNext[5]  = 1'b1;
      mstNext[8]  = 1'b0;
      mstNext[17] = 1'b0;
    end else if (uret) begin
      mstNext[0] = mstModel[4];
      mstNext[4] = 1'b1;
    end
    // Float write only loses to a write that carries FS
    if (floatRegWrite && !(legalWr && (csrAddr == privPkg::AddrMstatus ||
                                       csrAddr == privPkg::AddrSstatus)))
      mstNext[14:13] = 2'b11;
  end

  always @(posedge clk or posedge reset) begin
    if (reset) begin
      mstModel   <= '0;
      delegModel <= '0;
      modeModel  <= privPkg::MMode;
    end else if (!stall) begin                 // Stall freezes everything
      mstModel <= mstNext;
      if (legalWr && csrAddr == privPkg::AddrMedeleg)
        delegModel <= csrWdata[15:0];
      if (expTrap)
        modeModel <= expTarget;
      else if (mret)
        modeModel <= mstModel[12:11];
      else if (sret)
        modeModel <= mstModel[8] ? privPkg::SMode : privPkg::UMode;
      else if (uret)
        modeModel <= privPkg::UMode;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic reportMismatch(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
    $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
    $display("CHECKS FAILED");
    $fatal(1, "%s mismatch", name);
  endtask

  assert property (@(posedge clk) disable iff (reset) csrRdata == expRdata)
    else reportMismatch("csrRdata", $sampled(csrRdata), $sampled(expRdata));
  assert property (@(posedge clk) disable iff (reset) privilegeMode == modeModel)
    else reportMismatch("privilegeMode", 64'($sampled(privilegeMode)), 64'($sampled(modeModel)));
  assert property (@(posedge clk) disable iff (reset) trapTaken == expTrap)
    else reportMismatch("trapTaken", 64'($sampled(trapTaken)), 64'($sampled(expTrap)));
  assert property (@(posedge clk) disable iff (reset) illegalCsr == expIllegal)
    else reportMismatch("illegalCsr", 64'($sampled(illegalCsr)), 64'($sampled(expIllegal)));

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= CycleLimit) begin
      $display("Timeout: the test sequence did not finish within %0d cycles", CycleLimit);
      $display("CHECKS FAILED");
      $fatal(1, "timeout");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // Taps 16,14,13,11
  endfunction

  // One LFSR step per bit taken
  task automatic drawBits(input int n, output logic [63:0] w);
    w = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsrNext(lfsr);
      w    = {w[62:0], lfsr[0]};
    end
  endtask

  task automatic nextCycle();
    @(posedge clk);
    #1;
  endtask

  // Address stays put so the next cycle reads back
  task automatic writeCsr(input logic [11:0] addr, input logic [63:0] data);
    csrAddr  = addr;
    csrWdata = data;
    csrWrite = 1'b1;
    nextCycle();
    csrWrite = 1'b0;
    nextCycle();
  endtask

  task automatic readAll();
    csrAddr = privPkg::AddrMstatus;
    nextCycle();
    csrAddr = privPkg::AddrSstatus;
    nextCycle();
    csrAddr = privPkg::AddrUstatus;
    nextCycle();
    csrAddr = privPkg::AddrMedeleg;
    nextCycle();
  endtask

  task automatic raiseException(input logic [3:0] c);
    exceptionReq = 1'b1;
    cause        = c;
    nextCycle();
    exceptionReq = 1'b0;
    nextCycle();
  endtask

  initial begin
    logic [63:0] word;
    logic [3:0]  delegCause;
    reset = 1'b1;
    stall = 1'b0;
    csrWrite = 1'b0;
    csrAddr = '0;
    csrWdata = '0;
    exceptionReq = 1'b0;
    cause = '0;
    machineIrq = 1'b0;
    mret = 1'b0;
    sret = 1'b0;
    uret = 1'b0;
    floatRegWrite = 1'b0;
    repeat (2) @(posedge clk);
    #1 reset = 1'b0;
    readAll();                                 // Reset values

    // Random writes through all three views
    for (int i = 0; i < 6; i++) begin
      drawBits(64, word);
      writeCsr(privPkg::AddrMstatus, word);
      drawBits(64, word);
      writeCsr(privPkg::AddrSstatus, word);
      drawBits(64, word);
      writeCsr(privPkg::AddrUstatus, word);
    end
    writeCsr(privPkg::AddrMstatus, 64'h7000);  // MPP 10 and FS dirty
    writeCsr(privPkg::AddrMstatus, 64'h2000);  // FS initial, SD clear
    readAll();

    // Machine interrupt in M with MIE set, then mret
    writeCsr(privPkg::AddrMstatus, 64'h8);
    machineIrq = 1'b1;
    nextCycle();
    nextCycle();                               // MIE now clear, not taken
    machineIrq = 1'b0;
    mret = 1'b1;
    nextCycle();
    mret = 1'b0;
    nextCycle();

    // Delegated exception from U lands in S
    drawBits(4, word);
    delegCause = word[3:0];
    writeCsr(privPkg::AddrMedeleg, 64'd1 << delegCause);
    writeCsr(privPkg::AddrMstatus, 64'h2);     // SIE set, MPP U
    mret = 1'b1;
    nextCycle();
    mret = 1'b0;
    csrAddr = privPkg::AddrSstatus;
    raiseException(delegCause);
    sret = 1'b1;
    nextCycle();
    sret = 1'b0;
    csrAddr = privPkg::AddrUstatus;
    machineIrq = 1'b1;                         // Taken in U even with MIE clear
    nextCycle();
    machineIrq = 1'b0;
    mret = 1'b1;
    nextCycle();
    mret = 1'b0;
    raiseException(delegCause + 4'd1);         // Not delegated, goes to M
    raiseException(delegCause);                // From M stays in M
    csrAddr = privPkg::AddrMstatus;
    nextCycle();

    // Illegal writes from U and a stalled write
    writeCsr(privPkg::AddrMstatus, 64'h8);     // MPP U so mret drops to U
    mret = 1'b1;
    nextCycle();
    mret = 1'b0;
    drawBits(64, word);
    writeCsr(privPkg::AddrMstatus, word);
    writeCsr(privPkg::AddrSstatus, word);
    raiseException(delegCause + 4'd1);
    stall = 1'b1;
    drawBits(64, word);
    writeCsr(privPkg::AddrMstatus, word);
    raiseException(delegCause);
    stall = 1'b0;
    readAll();

    // Float register write marks FS dirty
    writeCsr(privPkg::AddrMstatus, 64'h0);
    floatRegWrite = 1'b1;
    nextCycle();
    floatRegWrite = 1'b0;
    readAll();

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
hdl/privPkg.sv
hdl/csrAccess.sv
hdl/statusReg.sv
hdl/privModeReg.sv
hdl/trapCtrl.sv
hdl/privCsrTop.sv
dv/privCsrTb.sv

// File: Makefile
# Verilator build of the privilege CSR block and its testbench

VERILATOR ?= verilator
TOP       ?= privCsrTb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass or fail comes from the printed output alone
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
